/* design/ctrlPipeline.sv */
/*
 * Control registers for the Execute, Memory and Writeback stages.
 * Execute holds the full bundle and takes a bubble on flush;
 * later stages keep only the memory and writeback fields.
 */

`timescale 1ns/100ps

module ctrlPipeline
    import pipeCtrlPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ctrlBundle_t ctrlD_i,
    input  logic        flushE_i,
    output ctrlBundle_t ctrlE_o,
    output logic        memWriteM_o,
    output logic        regWriteM_o,
    output resultSrc_t  resultSrcM_o,
    output logic        regWriteW_o,
    output resultSrc_t  resultSrcW_o
);

    // Execute stage
    // Flush covers load-use, mispredict and fetch stall
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            ctrlE_o <= '0;
        end else begin
            ctrlE_o <= ctrlD_i;
        end
    end

    // Memory stage
    // Branch, jump and ALU fields already consumed in Execute
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= RES_ALU;
        end else begin
            regWriteM_o  <= ctrlE_o.regWrite;
            memWriteM_o  <= ctrlE_o.memWrite;
            resultSrcM_o <= ctrlE_o.resultSrc;
        end
    end

    // Writeback stage
    // Store enable is not needed past Memory
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= RES_ALU;
        end else begin
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM_o;
        end
    end

    // A flushed slot in Execute carries no side effects
    flushGivesBubble: assert property (
        @(posedge clk) disable iff (reset)
        flushE_i |=> (ctrlE_o == '0)
    ) else $error("ctrlE not a bubble after flushE");

endmodule

/* design/hazardUnit.sv */
/*
 * Hazard detection for the five-stage pipeline.
 * Forwarding selects for both Execute operands, load-use and
 * fetch-miss stalls, and flushes on a branch mispredict.
 */

`timescale 1ns/100ps

module hazardUnit
    import pipeCtrlPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  regAddr_t   rs1D_i,
    input  regAddr_t   rs2D_i,
    input  regAddr_t   rs1E_i,
    input  regAddr_t   rs2E_i,
    input  regAddr_t   rdE_i,
    input  regAddr_t   rdM_i,
    input  regAddr_t   rdW_i,
    input  resultSrc_t resultSrcE_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       fetchReady_i,
    input  logic       mispredictE_i,
    output forward_t   forwardAE_o,
    output forward_t   forwardBE_o,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o
);

    logic firedOnce;
    logic loadStall;
    logic fetchMiss;

    // Bypass priority for one source register
    // Memory result is newer than Writeback
    function automatic forward_t fwdSelect(
        input regAddr_t rs,
        input regAddr_t rdM,
        input logic     wrM,
        input regAddr_t rdW,
        input logic     wrW
    );
        forward_t sel;
        sel = FWD_NONE;
        // x0 is hardwired and never bypassed
        if (rs != '0) begin
            if (wrM && (rs == rdM)) begin
                sel = FWD_MEM;
            end else if (wrW && (rs == rdW)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign forwardAE_o = fwdSelect(rs1E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);
    assign forwardBE_o = fwdSelect(rs2E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);

    // Set after the first cycle out of reset
    // Fetch has no valid PC to hold before that
    always_ff @(posedge clk) begin
        if (reset) begin
            firedOnce <= 1'b0;
        end else begin
            firedOnce <= 1'b1;
        end
    end

    // Load in Execute feeding the instruction in Decode
    assign loadStall = (resultSrcE_i == RES_MEM) && (rdE_i != '0) &&
                       ((rdE_i == rs1D_i) || (rdE_i == rs2D_i));

    // Instruction cache miss
    assign fetchMiss = !fetchReady_i;

    assign stallF_o = loadStall || mispredictE_i || (fetchMiss && firedOnce);
    assign stallD_o = loadStall || fetchMiss;
    assign flushD_o = mispredictE_i;
    // Bubble into Execute on fetch miss while Decode is held
    assign flushE_o = loadStall || mispredictE_i || fetchMiss;

    // Register 0 never takes a bypassed value
    noForwardFromX0: assert property (
        @(posedge clk) disable iff (reset)
        ((rs1E_i != '0) || (forwardAE_o == FWD_NONE)) &&
        ((rs2E_i != '0) || (forwardBE_o == FWD_NONE))
    ) else $error("forward select active for x0");

endmodule

/* design/instrDecoder.sv */
/*
 * Decode stage control for the supported RV32I subset.
 * Main decoder on the opcode plus ALU decoder on funct3/funct7b5.
 * Purely combinational; the bundle goes to the control pipeline.
 */

`timescale 1ns/100ps

module instrDecoder
    import pipeCtrlPkg::*;
(
    input  opcode_t     opcode_i,
    input  funct3_t     funct3_i,
    input  logic        funct7b5_i,
    output ctrlBundle_t ctrlD_o,
    output immSrc_t     immSrcD_o
);

    // ALU operation classes from the main decoder
    localparam logic [1:0] ALUOP_MEM    = 2'b00;
    localparam logic [1:0] ALUOP_BRANCH = 2'b01;
    localparam logic [1:0] ALUOP_FUNCT  = 2'b10;

    ctrlBundle_t mainCtrl;
    logic [1:0]  aluOp;
    logic        supported;
    logic        rtypeSub;
    aluCtrl_t    aluCtrl;

    // Main decoder
    always_comb begin
        mainCtrl  = '0;
        immSrcD_o = IMM_I;
        aluOp     = ALUOP_MEM;
        supported = 1'b1;
        case (opcode_i)
            OP_LW: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.resultSrc = RES_MEM;
            end
            OP_SW: begin
                immSrcD_o          = IMM_S;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.memWrite  = 1'b1;
            end
            OP_RTYPE: begin
                mainCtrl.regWrite  = 1'b1;
                aluOp              = ALUOP_FUNCT;
            end
            OP_BRANCH: begin
                immSrcD_o          = IMM_B;
                mainCtrl.branch    = 1'b1;
                aluOp              = ALUOP_BRANCH;
            end
            OP_ITYPE: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrc    = 1'b1;
                aluOp              = ALUOP_FUNCT;
            end
            OP_JAL: begin
                immSrcD_o          = IMM_J;
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSrc = RES_PC4;
                mainCtrl.jump      = 1'b1;
            end
            OP_JALR: begin
                // Target is rs1 + imm through the ALU
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.resultSrc = RES_PC4;
                mainCtrl.jump      = 1'b1;
            end
            OP_LUI: begin
                immSrcD_o          = IMM_U;
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSrc = RES_IMM;
            end
            default: begin
                supported          = 1'b0;
            end
        endcase
    end

    // Only R-type uses funct7b5 for sub, I-type has an immediate bit there
    assign rtypeSub = funct7b5_i & opcode_i[5];

    // ALU decoder
    always_comb begin
        aluCtrl = ALU_ADD;
        case (aluOp)
            ALUOP_MEM:    aluCtrl = ALU_ADD;
            ALUOP_BRANCH: aluCtrl = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct3_i)
                    F3_ADDSUB: aluCtrl = rtypeSub ? ALU_SUB : ALU_ADD;
                    F3_SLT:    aluCtrl = ALU_SLT;
                    F3_OR:     aluCtrl = ALU_OR;
                    F3_AND:    aluCtrl = ALU_AND;
                    default:   aluCtrl = ALU_ADD;
                endcase
            end
            default:      aluCtrl = ALU_ADD;
        endcase
    end

    // Merge into the outgoing bundle
    always_comb begin
        ctrlD_o            = mainCtrl;
        ctrlD_o.branchType = mainCtrl.branch && (funct3_i == F3_BNE);
        ctrlD_o.aluControl = aluCtrl;
        // Unknown opcode becomes a bubble
        if (!supported) begin
            ctrlD_o = '0;
        end
    end

    // Branches reaching Execute must be beq or bne
    branchFunct3Legal: assert final (
        !ctrlD_o.branch || (funct3_i == F3_BEQ) || (funct3_i == F3_BNE)
    ) else $error("branch decoded with unsupported funct3 %b", funct3_i);

endmodule

/* design/pipeController.sv */
/*
 * Top level of the pipeline control path.
 * Decoder feeds the control pipeline; the hazard unit reads
 * stage flags back from it and drives the Execute flush.
 */

`timescale 1ns/100ps

module pipeController
    import pipeCtrlPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    // Decode instruction fields
    input  opcode_t     opcode_i,
    input  funct3_t     funct3_i,
    input  logic        funct7b5_i,
    // Register addresses per stage
    input  regAddr_t    rs1D_i,
    input  regAddr_t    rs2D_i,
    input  regAddr_t    rs1E_i,
    input  regAddr_t    rs2E_i,
    input  regAddr_t    rdE_i,
    input  regAddr_t    rdM_i,
    input  regAddr_t    rdW_i,
    input  logic        fetchReady_i,
    input  logic        mispredictE_i,
    output immSrc_t     immSrcD_o,
    output ctrlBundle_t ctrlE_o,
    output forward_t    forwardAE_o,
    output forward_t    forwardBE_o,
    output logic        stallF_o,
    output logic        stallD_o,
    output logic        flushD_o,
    output logic        flushE_o,
    output logic        memWriteM_o,
    output resultSrc_t  resultSrcM_o,
    output logic        regWriteW_o,
    output resultSrc_t  resultSrcW_o
);

    ctrlBundle_t ctrlD;
    logic        regWriteM;

    // Decode stage control
    instrDecoder decoder (
        .opcode_i   (opcode_i),
        .funct3_i   (funct3_i),
        .funct7b5_i (funct7b5_i),
        .ctrlD_o    (ctrlD),
        .immSrcD_o  (immSrcD_o)
    );

    // E, M and W control registers
    ctrlPipeline pipeline (
        .clk          (clk),
        .reset        (reset),
        .ctrlD_i      (ctrlD),
        .flushE_i     (flushE_o),
        .ctrlE_o      (ctrlE_o),
        .memWriteM_o  (memWriteM_o),
        .regWriteM_o  (regWriteM),
        .resultSrcM_o (resultSrcM_o),
        .regWriteW_o  (regWriteW_o),
        .resultSrcW_o (resultSrcW_o)
    );

    // Load detection looks at the resultSrc in Execute
    hazardUnit hazards (
        .clk           (clk),
        .reset         (reset),
        .rs1D_i        (rs1D_i),
        .rs2D_i        (rs2D_i),
        .rs1E_i        (rs1E_i),
        .rs2E_i        (rs2E_i),
        .rdE_i         (rdE_i),
        .rdM_i         (rdM_i),
        .rdW_i         (rdW_i),
        .resultSrcE_i  (ctrlE_o.resultSrc),
        .regWriteM_i   (regWriteM),
        .regWriteW_i   (regWriteW_o),
        .fetchReady_i  (fetchReady_i),
        .mispredictE_i (mispredictE_i),
        .forwardAE_o   (forwardAE_o),
        .forwardBE_o   (forwardBE_o),
        .stallF_o      (stallF_o),
        .stallD_o      (stallD_o),
        .flushD_o      (flushD_o),
        .flushE_o      (flushE_o)
    );

endmodule

/* design/pipeCtrlPkg.sv */
/*
 * Shared types and codes for the RV32I pipeline controller.
 * Decoder, control pipeline, hazard unit and testbench import it with pkg::*.
 * The control bundle struct is what travels from Decode down to Writeback.
 */

package pipeCtrlPkg;

    // Instruction field widths
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [4:0] regAddr_t;

    // ALU operation select
    typedef logic [2:0] aluCtrl_t;
    localparam aluCtrl_t ALU_ADD = 3'b000;
    localparam aluCtrl_t ALU_SUB = 3'b001;
    localparam aluCtrl_t ALU_AND = 3'b010;
    localparam aluCtrl_t ALU_OR  = 3'b011;
    localparam aluCtrl_t ALU_SLT = 3'b101;

    // Immediate formats for the extend unit
    typedef logic [2:0] immSrc_t;
    localparam immSrc_t IMM_I = 3'b000;
    localparam immSrc_t IMM_S = 3'b001;
    localparam immSrc_t IMM_B = 3'b010;
    localparam immSrc_t IMM_J = 3'b011;
    localparam immSrc_t IMM_U = 3'b100;

    // Writeback result mux
    typedef logic [1:0] resultSrc_t;
    localparam resultSrc_t RES_ALU = 2'b00;
    localparam resultSrc_t RES_MEM = 2'b01;
    localparam resultSrc_t RES_PC4 = 2'b10;
    localparam resultSrc_t RES_IMM = 2'b11;

    // Operand bypass select in Execute
    typedef logic [1:0] forward_t;
    localparam forward_t FWD_NONE = 2'b00;
    localparam forward_t FWD_WB   = 2'b01;
    localparam forward_t FWD_MEM  = 2'b10;

    // Supported opcodes
    localparam opcode_t OP_LW     = 7'b0000011;
    localparam opcode_t OP_SW     = 7'b0100011;
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;

    // funct3 codes, ALU group and branch group overlap
    localparam funct3_t F3_ADDSUB = 3'b000;
    localparam funct3_t F3_SLT    = 3'b010;
    localparam funct3_t F3_OR     = 3'b110;
    localparam funct3_t F3_AND    = 3'b111;
    localparam funct3_t F3_BEQ    = 3'b000;
    localparam funct3_t F3_BNE    = 3'b001;

    // Control bundle, all zero is a bubble
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        resultSrc_t resultSrc;
        logic       branch;
        // Set for bne, inverts the zero flag
        logic       branchType;
        logic       jump;
        logic       aluSrc;
        aluCtrl_t   aluControl;
    } ctrlBundle_t;

endpackage

/* pipeController.f */
design/pipeCtrlPkg.sv
design/instrDecoder.sv
design/ctrlPipeline.sv
design/hazardUnit.sv
design/pipeController.sv
verification/clockGen.sv
verification/ctrlChecker.sv
verification/pipeControllerTb.sv

/* verification/clockGen.sv */
/*
 * Testbench clock and reset source.
 * 4 ns clock, reset held high for the first 5 cycles.
 */

`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* verification/ctrlChecker.sv */
/*
 * Testbench checker for the pipeline controller.
 * Models the E, M and W control stages and the first-cycle flag,
 * compares every DUT output on rising edges and counts errors.
 */

`timescale 1ns/100ps

module ctrlChecker
    import pipeCtrlPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [8*12-1:0] testName_i,
    // Reference decode of the instruction in Decode
    input  ctrlBundle_t     expCtrlD_i,
    input  immSrc_t         expImmSrc_i,
    input  regAddr_t        rs1D_i, rs2D_i, rs1E_i, rs2E_i, rdE_i, rdM_i, rdW_i,
    input  logic            fetchReady_i, mispredictE_i,
    // Observed DUT outputs
    input  immSrc_t         immSrcD_i,
    input  ctrlBundle_t     ctrlE_i,
    input  forward_t        forwardAE_i, forwardBE_i,
    input  logic            stallF_i, stallD_i, flushD_i, flushE_i,
    input  logic            memWriteM_i, regWriteW_i,
    input  resultSrc_t      resultSrcM_i, resultSrcW_i,
    output int              errorCount_o,
    output int              checkCount_o
);

    // Index 0 is Execute, 1 Memory, 2 Writeback
    ctrlBundle_t stage [3];
    logic        pastFirst;
    logic        loadUse;
    logic        expFlushE;
    int          errors = 0;
    int          checks = 0;

    assign errorCount_o = errors;
    assign checkCount_o = checks;

    // Newest producer wins; x0 never bypassed
    function automatic forward_t expectFwd(input regAddr_t rs);
        if (rs == 5'd0) return FWD_NONE;
        if (stage[1].regWrite && (rs == rdM_i)) return FWD_MEM;
        if (stage[2].regWrite && (rs == rdW_i)) return FWD_WB;
        return FWD_NONE;
    endfunction

    task automatic compareField(input string what, input logic [12:0] expected,
                                input logic [12:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0s %0s: expected %h, actual %h",
                     testName_i, what, expected, actual);
        end
    endtask

    // Load in Execute whose rd is read in Decode
    assign loadUse = (stage[0].resultSrc == RES_MEM) && (rdE_i != 5'd0) &&
                     ((rdE_i == rs1D_i) || (rdE_i == rs2D_i));
    assign expFlushE = loadUse || mispredictE_i || !fetchReady_i;

    always @(posedge clk) begin
        if (reset) begin
            stage[0]  <= '0;
            stage[1]  <= '0;
            stage[2]  <= '0;
            pastFirst <= 1'b0;
        end else begin
            compareField("immSrcD", expImmSrc_i, immSrcD_i);
            compareField("ctrlE", stage[0], ctrlE_i);
            compareField("memWriteM", stage[1].memWrite, memWriteM_i);
            compareField("resultSrcM", stage[1].resultSrc, resultSrcM_i);
            compareField("regWriteW", stage[2].regWrite, regWriteW_i);
            compareField("resultSrcW", stage[2].resultSrc, resultSrcW_i);
            compareField("forwardAE", expectFwd(rs1E_i), forwardAE_i);
            compareField("forwardBE", expectFwd(rs2E_i), forwardBE_i);
            // Fetch miss ignored for F in the first cycle out of reset
            compareField("stallF",
                         loadUse || mispredictE_i || (!fetchReady_i && pastFirst), stallF_i);
            compareField("stallD", loadUse || !fetchReady_i, stallD_i);
            compareField("flushD", mispredictE_i, flushD_i);
            compareField("flushE", expFlushE, flushE_i);
            // Advance model, bubble into Execute on flush
            stage[0]  <= expFlushE ? '0 : expCtrlD_i;
            stage[1]  <= stage[0];
            stage[2]  <= stage[1];
            pastFirst <= 1'b1;
        end
    end

endmodule

/* verification/pipeControllerTb.sv */
/*
 * Testbench top for the pipeline controller.
 * Drives directed and xorshift-random instructions on falling edges,
 * computes the expected decode and prints the verdict.
 */

`timescale 1ns/100ps

module pipeControllerTb
    import pipeCtrlPkg::*;
();

    localparam int RANDOM_CYCLES = 400;
    localparam int RESET_TIMEOUT = 50;

    logic            clk, reset;
    opcode_t         opcode_i;
    funct3_t         funct3_i;
    logic            funct7b5_i;
    regAddr_t        rs1D_i, rs2D_i, rs1E_i, rs2E_i, rdE_i, rdM_i, rdW_i;
    logic            fetchReady_i, mispredictE_i;
    immSrc_t         immSrcD_o;
    ctrlBundle_t     ctrlE_o;
    forward_t        forwardAE_o, forwardBE_o;
    logic            stallF_o, stallD_o, flushD_o, flushE_o, memWriteM_o, regWriteW_o;
    resultSrc_t      resultSrcM_o, resultSrcW_o;
    ctrlBundle_t     expCtrlD;
    immSrc_t         expImmSrc;
    logic [8*12-1:0] testName;
    int              errorCount, checkCount, cycles;
    logic [31:0]     rnd;

    clockGen clocks (.clk(clk), .reset(reset));

    pipeController uut (.*);

    ctrlChecker scoreboard (
        .clk(clk), .reset(reset), .testName_i(testName),
        .expCtrlD_i(expCtrlD), .expImmSrc_i(expImmSrc),
        .rs1D_i(rs1D_i), .rs2D_i(rs2D_i), .rs1E_i(rs1E_i), .rs2E_i(rs2E_i),
        .rdE_i(rdE_i), .rdM_i(rdM_i), .rdW_i(rdW_i),
        .fetchReady_i(fetchReady_i), .mispredictE_i(mispredictE_i),
        .immSrcD_i(immSrcD_o), .ctrlE_i(ctrlE_o),
        .forwardAE_i(forwardAE_o), .forwardBE_i(forwardBE_o),
        .stallF_i(stallF_o), .stallD_i(stallD_o), .flushD_i(flushD_o), .flushE_i(flushE_o),
        .memWriteM_i(memWriteM_o), .resultSrcM_i(resultSrcM_o),
        .regWriteW_i(regWriteW_o), .resultSrcW_i(resultSrcW_o),
        .errorCount_o(errorCount), .checkCount_o(checkCount)
    );

    // Expected bundle built field by field from the decode table
    function automatic ctrlBundle_t decodeControl(input opcode_t op, input funct3_t f3,
                                                  input logic f7b5);
        ctrlBundle_t c;
        c.regWrite   = !((op == OP_SW) || (op == OP_BRANCH));
        c.memWrite   = (op == OP_SW);
        c.branch     = (op == OP_BRANCH);
        c.branchType = (op == OP_BRANCH) && (f3 == F3_BNE);
        c.jump       = (op == OP_JAL) || (op == OP_JALR);
        c.aluSrc     = (op == OP_LW) || (op == OP_SW) || (op == OP_ITYPE) || (op == OP_JALR);
        c.resultSrc  = (op == OP_LW) ? RES_MEM : c.jump ? RES_PC4 :
                       (op == OP_LUI) ? RES_IMM : RES_ALU;
        c.aluControl = (op == OP_BRANCH) ? ALU_SUB : ALU_ADD;
        if ((op == OP_RTYPE) || (op == OP_ITYPE)) begin
            case (f3)
                F3_ADDSUB: c.aluControl = (op == OP_RTYPE && f7b5) ? ALU_SUB : ALU_ADD;
                F3_SLT:    c.aluControl = ALU_SLT;
                F3_OR:     c.aluControl = ALU_OR;
                F3_AND:    c.aluControl = ALU_AND;
                default:   c.aluControl = ALU_ADD;
            endcase
        end
        // Anything outside the subset is a bubble
        case (op)
            OP_LW, OP_SW, OP_RTYPE, OP_BRANCH, OP_ITYPE, OP_JAL, OP_JALR, OP_LUI: ;
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic immSrc_t immFormatOf(input opcode_t op);
        case (op)
            OP_SW:     return IMM_S;
            OP_BRANCH: return IMM_B;
            OP_JAL:    return IMM_J;
            OP_LUI:    return IMM_U;
            default:   return IMM_I;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic applyInstr(input opcode_t op, input funct3_t f3, input logic f7b5);
        opcode_i   = op;
        funct3_i   = f3;
        funct7b5_i = f7b5;
        expCtrlD   = decodeControl(op, f3, f7b5);
        expImmSrc  = immFormatOf(op);
    endtask

    // One random instruction plus register addresses from x0..x3
    task automatic randomCycle();
        opcode_t op;
        funct3_t f3;
        rnd = xorshift(rnd);
        case (rnd[2:0])
            3'd0:    op = OP_LW;
            3'd1:    op = OP_SW;
            3'd2:    op = OP_RTYPE;
            3'd3:    op = OP_BRANCH;
            3'd4:    op = OP_ITYPE;
            3'd5:    op = OP_JAL;
            3'd6:    op = OP_JALR;
            default: op = OP_LUI;
        endcase
        case (rnd[4:3])
            2'd0:    f3 = F3_ADDSUB;
            2'd1:    f3 = F3_SLT;
            2'd2:    f3 = F3_OR;
            default: f3 = F3_AND;
        endcase
        if (op == OP_BRANCH) begin
            f3 = rnd[3] ? F3_BNE : F3_BEQ;
        end
        applyInstr(op, f3, rnd[20]);
        rs1D_i        = {3'b0, rnd[7:6]};
        rs2D_i        = {3'b0, rnd[9:8]};
        rs1E_i        = {3'b0, rnd[11:10]};
        rs2E_i        = {3'b0, rnd[13:12]};
        rdE_i         = {3'b0, rnd[15:14]};
        rdM_i         = {3'b0, rnd[17:16]};
        rdW_i         = {3'b0, rnd[19:18]};
        fetchReady_i  = (rnd[23:21] != 3'd0);
        mispredictE_i = (rnd[27:24] == 4'd0);
    endtask

    initial begin
        rnd      = 32'hc29268f0;
        testName = "reset";
        applyInstr(OP_ITYPE, F3_ADDSUB, 1'b0);
        {rs1D_i, rs2D_i, rs1E_i, rs2E_i, rdE_i, rdM_i, rdW_i} = '0;
        // Fetch not ready across the first cycle out of reset
        fetchReady_i  = 1'b0;
        mispredictE_i = 1'b0;
        cycles = 0;
        while (reset && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("Timeout: reset was never released");
            $display("=== FAIL ===");
            $finish;
        end
        @(negedge clk);
        testName = "fetchStall";
        @(negedge clk);
        fetchReady_i = 1'b1;
        // lw then a consumer of its rd
        @(negedge clk);
        testName = "loadUse";
        applyInstr(OP_LW, 3'b010, 1'b0);
        rs1D_i = 5'd1;
        rs2D_i = 5'd2;
        @(negedge clk);
        applyInstr(OP_RTYPE, F3_ADDSUB, 1'b1);
        rs1D_i = 5'd5;
        rdE_i  = 5'd5;
        @(negedge clk);
        rdE_i = 5'd0;
        // Load to x0 must not stall
        @(negedge clk);
        testName = "loadX0";
        applyInstr(OP_LW, 3'b010, 1'b0);
        @(negedge clk);
        applyInstr(OP_RTYPE, F3_OR, 1'b0);
        rs1D_i = 5'd0;
        @(negedge clk);
        testName = "mispredict";
        applyInstr(OP_BRANCH, F3_BNE, 1'b0);
        mispredictE_i = 1'b1;
        @(negedge clk);
        mispredictE_i = 1'b0;
        fetchReady_i  = 1'b0;
        @(negedge clk);
        fetchReady_i = 1'b1;
        testName = "random";
        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            randomCycle();
        end
        // Let the last instructions reach Writeback
        testName = "drain";
        @(negedge clk);
        applyInstr(OP_ITYPE, F3_ADDSUB, 1'b0);
        fetchReady_i  = 1'b1;
        mispredictE_i = 1'b0;
        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if ((errorCount == 0) && (checkCount > 0)) begin
            $display("=== PASS ===");
        end else begin
            if (checkCount == 0) begin
                $display("No checks were performed");
            end
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
